/* cga_mic.f */
mic_pkg.sv
mic_loop_counter.sv
mic_operand_select.sv
mic_cond_select.sv
mic_return_stack.sv
mic_addr_select.sv
cga_mic.sv
cga_mic_tb.sv

/* cga_mic.sv */
`timescale 1ns/1ps
`default_nettype none

module cga_mic (
  input  logic                       mclk,
  input  logic                       rst,
  input  logic [15:0]                cd,
  input  logic [15:0]                csbit,
  input  logic                       cscond,
  input  logic                       csloop,
  input  logic [mic_pkg::SC_W-1:0]   csts,
  input  logic [1:0]                 csrasel,
  input  logic [1:0]                 csrbsel,
  input  logic [mic_pkg::REG_W-1:0]  csrb,
  input  logic [mic_pkg::REG_W-1:0]  pil,
  input  logic                       ldirv,
  input  logic                       ldlc,
  input  logic                       zf,
  input  logic                       cry,
  input  logic                       ovf,
  input  logic                       irq,
  input  logic                       stp,
  input  logic                       f11,
  input  logic                       f15,
  output logic [mic_pkg::ADDR_W-1:0] ma,
  output logic [mic_pkg::REG_W-1:0]  laa,
  output logic [mic_pkg::REG_W-1:0]  lba,
  output logic                       cond,
  output logic [mic_pkg::SC_W-1:0]   sc,
  output logic                       deep,
  output logic                       loop_done
);

  mic_pkg::mic_word_t         word;
  logic [7:0]                 tests;
  logic [mic_pkg::REG_W-1:0]  lcc;
  logic [mic_pkg::LOOP_W-1:0] lc;
  logic [mic_pkg::ADDR_W-1:0] next_addr;
  logic [mic_pkg::ADDR_W-1:0] ret;

  assign word = csbit[11:0];

  assign tests[mic_pkg::TEST_ZF]        = zf;
  assign tests[mic_pkg::TEST_CRY]       = cry;
  assign tests[mic_pkg::TEST_OVF]       = ovf;
  assign tests[mic_pkg::TEST_IRQ]       = irq;
  assign tests[mic_pkg::TEST_STP]       = stp;
  assign tests[mic_pkg::TEST_F11]       = f11;
  assign tests[mic_pkg::TEST_F15]       = f15;
  assign tests[mic_pkg::TEST_LOOP_DONE] = loop_done;

  mic_cond_select i_cond_select (
    .mclk   (mclk),
    .rst    (rst),
    .cscond (cscond),
    .word   (word),
    .tests  (tests),
    .csts   (csts),
    .lcc    (lcc),
    .cond   (cond),
    .sc     (sc)
  );

  mic_loop_counter i_loop_counter (
    .mclk      (mclk),
    .rst       (rst),
    .ldlc      (ldlc),
    .csloop    (csloop),
    .load_val  (cd[mic_pkg::LOOP_W-1:0]),
    .lcc       (lcc),
    .lc        (lc),
    .loop_done (loop_done)
  );

  mic_operand_select i_operand_select (
    .mclk    (mclk),
    .rst     (rst),
    .ldirv   (ldirv),
    .cd_ir   (cd[6:0]),
    .csrasel (csrasel),
    .csrbsel (csrbsel),
    .csa     (csbit[15:12]),
    .csrb    (csrb),
    .pil     (pil),
    .lc      (lc[mic_pkg::REG_W-1:0]),  // Low nibble only
    .laa     (laa),
    .lba     (lba)
  );

  mic_return_stack i_return_stack (
    .mclk      (mclk),
    .rst       (rst),
    .stack_op  (sc[1:0]),
    .next_addr (next_addr),
    .ret       (ret),
    .deep      (deep)
  );

  mic_addr_select i_addr_select (
    .mclk      (mclk),
    .rst       (rst),
    .addr_src  (sc[3:2]),
    .word      (word),
    .ret       (ret),
    .ma        (ma),
    .next_addr (next_addr)
  );

endmodule

`default_nettype wire

/* cga_mic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cga_mic_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SEQ_CYCLES   = 300;
  localparam int STACK_CYCLES = 60;
  localparam int LOOP_ROUNDS  = 8;
  localparam int LOOP_LEN     = 24;
  localparam int REG_CYCLES   = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + SEQ_CYCLES + STACK_CYCLES +
                                LOOP_ROUNDS * LOOP_LEN + REG_CYCLES;

  logic                       mclk;
  logic                       rst;
  logic [15:0]                cd;
  logic [15:0]                csbit;
  logic                       cscond;
  logic                       csloop;
  logic [mic_pkg::SC_W-1:0]   csts;
  logic [1:0]                 csrasel;
  logic [1:0]                 csrbsel;
  logic [mic_pkg::REG_W-1:0]  csrb;
  logic [mic_pkg::REG_W-1:0]  pil;
  logic                       ldirv;
  logic                       ldlc;
  logic                       zf, cry, ovf, irq, stp, f11, f15;
  logic [mic_pkg::ADDR_W-1:0] ma;
  logic [mic_pkg::REG_W-1:0]  laa;
  logic [mic_pkg::REG_W-1:0]  lba;
  logic                       cond;
  logic [mic_pkg::SC_W-1:0]   sc;
  logic                       deep;
  logic                       loop_done;

  // Cycle model state
  logic [mic_pkg::ADDR_W-1:0] m_ma;
  logic [mic_pkg::ADDR_W-1:0] m_stk[$];  // Front is the top of stack
  logic [mic_pkg::REG_W-1:0]  m_lcc;
  logic [mic_pkg::SC_W-1:0]   m_fs;
  logic [3:0]                 m_tsel;
  logic                       m_cond;
  logic [mic_pkg::LOOP_W-1:0] m_lc;
  logic [6:0]                 m_ir;
  logic [mic_pkg::REG_W-1:0]  m_laa;
  logic [mic_pkg::REG_W-1:0]  m_lba;

  logic [15:0] lfsr;
  string       cur_test;
  int          test_errors;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;

  cga_mic i_cga_mic (
    .mclk(mclk), .rst(rst), .cd(cd), .csbit(csbit), .cscond(cscond), .csloop(csloop),
    .csts(csts), .csrasel(csrasel), .csrbsel(csrbsel), .csrb(csrb), .pil(pil),
    .ldirv(ldirv), .ldlc(ldlc), .zf(zf), .cry(cry), .ovf(ovf), .irq(irq), .stp(stp),
    .f11(f11), .f15(f15), .ma(ma), .laa(laa), .lba(lba), .cond(cond), .sc(sc),
    .deep(deep), .loop_done(loop_done)
  );

  always #(CLK_PERIOD / 2) mclk = ~mclk;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic model_loop_done();
    return (m_lc[5:4] == 2'b00) && (m_lc[3:0] == m_lcc);
  endfunction

  function automatic logic [mic_pkg::SC_W-1:0] model_sc();
    return m_cond ? csts : m_fs;
  endfunction

  task automatic check_addr(input string label, input logic [mic_pkg::ADDR_W-1:0] exp,
                            input logic [mic_pkg::ADDR_W-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors++;
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, label, exp, act);
    end
  endtask

  task automatic check_reg(input string label, input logic [mic_pkg::REG_W-1:0] exp,
                           input logic [mic_pkg::REG_W-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors++;
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, label, exp, act);
    end
  endtask

  task automatic check_bit(input string label, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors++;
      $display("** Error %s %s: expected %0b, actual %0b", cur_test, label, exp, act);
    end
  endtask

  task automatic check_sc(input string label, input logic [mic_pkg::SC_W-1:0] exp,
                          input logic [mic_pkg::SC_W-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors++;
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, label, exp, act);
    end
  endtask

  task automatic reset_model();
    m_ma   = '0;
    m_stk.delete();
    m_lcc  = '0;
    m_fs   = '0;
    m_tsel = '0;
    m_cond = 1'b0;
    m_lc   = '0;
    m_ir   = '0;
    m_laa  = '0;
    m_lba  = '0;
  endtask

  // Steps the model with the inputs held over the coming edge
  task automatic advance_model();
    logic [7:0]                 flags;
    logic [15:0]                tv;
    logic [mic_pkg::SC_W-1:0]   sc_now;
    logic [mic_pkg::ADDR_W-1:0] inc;
    logic [mic_pkg::ADDR_W-1:0] top;
    if (rst) begin
      reset_model();
    end else begin
      flags  = {model_loop_done(), f15, f11, stp, irq, ovf, cry, zf};
      tv     = {~flags, flags};
      sc_now = model_sc();
      inc    = m_ma + 1'b1;
      top    = (m_stk.size() > 0) ? m_stk[0] : '0;  // Empty stack reads zero
      case (csrasel)
        2'd0:    m_laa = csbit[15:12];
        2'd1:    m_laa = pil;
        2'd2:    m_laa = m_ir[6:3];
        default: m_laa = m_lc[3:0];
      endcase
      case (csrbsel)
        2'd0:    m_lba = csrb;
        2'd1:    m_lba = {1'b0, m_ir[2:0]};
        2'd2:    m_lba = {1'b0, m_ir[5:3]};
        default: m_lba = m_lc[3:0];
      endcase
      m_cond = tv[m_tsel];  // Old select
      if (cscond) begin
        m_lcc  = csbit[11:8];
        m_fs   = csbit[7:4];
        m_tsel = csbit[3:0];
      end
      if (ldlc) m_lc = cd[5:0];
      else if (csloop && m_lc != '0) m_lc = m_lc - 1'b1;
      if (ldirv) m_ir = cd[6:0];
      case (sc_now[1:0])
        mic_pkg::STK_PUSH: begin
          m_stk.push_front(inc);
          if (m_stk.size() > mic_pkg::STACK_DEPTH) m_stk.delete(mic_pkg::STACK_DEPTH);
        end
        mic_pkg::STK_POP:  if (m_stk.size() > 0) m_stk.delete(0);
        mic_pkg::STK_LOAD: begin
          if (m_stk.size() == 0) m_stk.push_front(inc);
          else m_stk[0] = inc;
        end
        default: ;
      endcase
      case (sc_now[3:2])
        mic_pkg::SRC_NEXT: m_ma = inc;
        mic_pkg::SRC_JUMP: m_ma = {1'b0, csbit[11:0]};
        mic_pkg::SRC_RET:  m_ma = top;
        default:           m_ma = m_ma;
      endcase
    end
  endtask

  task automatic check_outputs();
    check_addr("ma", m_ma, ma);
    check_reg("laa", m_laa, laa);
    check_reg("lba", m_lba, lba);
    check_bit("cond", m_cond, cond);
    check_bit("deep", m_stk.size() == mic_pkg::STACK_DEPTH, deep);
    check_bit("loop_done", model_loop_done(), loop_done);
    check_sc("sc", model_sc(), sc);
  endtask

  // Called right after a rising edge
  task automatic drive_random();
    cd      <= 16'(take_bits(16));
    csbit   <= 16'(take_bits(16));
    cscond  <= 1'(take_bits(1));
    csloop  <= 1'(take_bits(1));
    csts    <= 4'(take_bits(4));
    csrasel <= 2'(take_bits(2));
    csrbsel <= 2'(take_bits(2));
    csrb    <= 4'(take_bits(4));
    pil     <= 4'(take_bits(4));
    ldirv   <= 1'(take_bits(1));
    ldlc    <= (take_bits(2) == 0);  // Rare loads
    {zf, cry, ovf, irq, stp, f11, f15} <= 7'(take_bits(7));
  endtask

  task automatic finish_cycle();
    @(negedge mclk);
    check_outputs();
    advance_model();
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %s: %s (%0d errors)", cur_test, test_errors ? "failed" : "passed",
             test_errors);
  endtask

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: the run did not finish within %0d ns", TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [mic_pkg::SC_W-1:0]  code;
    logic [mic_pkg::REG_W-1:0] lcc_val;
    mclk    = 1'b0;
    rst     = 1'b1;
    cd      = '0;
    csbit   = '0;
    cscond  = 1'b0;
    csloop  = 1'b0;
    csts    = '0;
    csrasel = '0;
    csrbsel = '0;
    csrb    = '0;
    pil     = '0;
    ldirv   = 1'b0;
    ldlc    = 1'b0;
    {zf, cry, ovf, irq, stp, f11, f15} = '0;
    lfsr         = 16'd66;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_model();

    start_test("reset");
    repeat (RESET_CYCLES - 1) @(posedge mclk);
    @(negedge mclk);
    check_addr("ma", '0, ma);
    check_reg("laa", '0, laa);
    check_reg("lba", '0, lba);
    check_bit("cond", 1'b0, cond);
    check_bit("deep", 1'b0, deep);
    check_sc("sc", '0, sc);
    @(posedge mclk);
    rst <= 1'b0;
    drive_random();
    finish_cycle();
    finish_test();

    start_test("sequencing");
    for (int i = 0; i < SEQ_CYCLES; i++) begin
      @(posedge mclk);
      drive_random();
      finish_cycle();
    end
    finish_test();

    // fs steers the stack while zf keeps cond low
    start_test("return_stack");
    for (int i = 0; i < STACK_CYCLES; i++) begin
      if (i < 6) code = {mic_pkg::SRC_NEXT, mic_pkg::STK_PUSH};
      else if (i == 6) code = {mic_pkg::SRC_JUMP, mic_pkg::STK_LOAD};
      else if (i < 13) code = {mic_pkg::SRC_RET, mic_pkg::STK_POP};
      else code = 4'(take_bits(4));
      @(posedge mclk);
      drive_random();
      cscond <= 1'b1;
      csbit  <= {8'(take_bits(8)), code, 4'(mic_pkg::TEST_ZF)};
      zf     <= 1'b0;
      finish_cycle();
    end
    finish_test();

    // Load value sits up to 15 above lcc so the count crosses it in each round
    start_test("loop_counter");
    for (int r = 0; r < LOOP_ROUNDS; r++) begin
      for (int j = 0; j < LOOP_LEN; j++) begin
        @(posedge mclk);
        drive_random();
        csrasel <= 2'd3;
        csrbsel <= 2'd3;
        ldlc    <= (j == 0);
        cscond  <= (j == 0);
        csloop  <= (j != 0);
        if (j == 0) begin
          lcc_val = 4'(take_bits(4));
          csbit <= {4'(take_bits(4)), lcc_val, 8'(take_bits(8))};
          cd    <= {10'(take_bits(10)), 6'(lcc_val) + 6'(take_bits(4))};
        end
        finish_cycle();
      end
    end
    finish_test();

    start_test("register_addresses");
    for (int i = 0; i < REG_CYCLES; i++) begin
      @(posedge mclk);
      drive_random();
      finish_cycle();
    end
    finish_test();

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mic_addr_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_addr_select (
  input  logic                       mclk,
  input  logic                       rst,
  input  logic [1:0]                 addr_src,
  input  mic_pkg::mic_word_t         word,
  input  logic [mic_pkg::ADDR_W-1:0] ret,
  output logic [mic_pkg::ADDR_W-1:0] ma,
  output logic [mic_pkg::ADDR_W-1:0] next_addr
);

  logic [mic_pkg::ADDR_W-1:0] jump_addr;
  logic [mic_pkg::ADDR_W-1:0] ma_d;

  // Incrementer, wraps at the top of the control store
  assign next_addr = ma + 1'b1;

  // Target field zero extended to full address
  assign jump_addr = mic_pkg::ADDR_W'(word.target);

  always_comb begin
    case (addr_src)
      mic_pkg::SRC_NEXT: ma_d = next_addr;
      mic_pkg::SRC_JUMP: ma_d = jump_addr;
      mic_pkg::SRC_RET:  ma_d = ret;     // Return from subroutine
      mic_pkg::SRC_HOLD: ma_d = ma;
      default:           ma_d = ma;
    endcase
  end

  // Micro-address register
  always_ff @(posedge mclk) begin
    if (rst) begin
      ma <= '0;
    end else begin
      ma <= ma_d;
    end
  end

endmodule

`default_nettype wire

/* mic_cond_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_cond_select (
  input  logic                      mclk,
  input  logic                      rst,
  input  logic                      cscond,
  input  mic_pkg::mic_word_t        word,
  input  logic [7:0]                tests,
  input  logic [mic_pkg::SC_W-1:0]  csts,
  output logic [mic_pkg::REG_W-1:0] lcc,
  output logic                      cond,
  output logic [mic_pkg::SC_W-1:0]  sc
);

  logic [mic_pkg::SC_W-1:0] fs;
  logic [3:0]               tsel;
  logic [15:0]              test_vec;

  // Condition register
  always_ff @(posedge mclk) begin
    if (rst) begin
      lcc  <= '0;
      fs   <= '0;
      tsel <= '0;
    end else if (cscond) begin
      lcc  <= word.fields.lcc;
      fs   <= word.fields.fs;
      tsel <= word.fields.tsel;
    end
  end

  assign test_vec = {~tests, tests};    // Upper half tests for false

  always_ff @(posedge mclk) begin
    if (rst) begin
      cond <= 1'b0;
    end else begin
      cond <= test_vec[tsel];           // Always the latched select
    end
  end

  // True branch comes from the live micro-word field
  assign sc = cond ? csts : fs;

endmodule

`default_nettype wire

/* mic_loop_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_loop_counter (
  input  logic                       mclk,
  input  logic                       rst,
  input  logic                       ldlc,
  input  logic                       csloop,
  input  logic [mic_pkg::LOOP_W-1:0] load_val,
  input  logic [mic_pkg::REG_W-1:0]  lcc,
  output logic [mic_pkg::LOOP_W-1:0] lc,
  output logic                       loop_done
);

  logic count_zero;

  assign count_zero = (lc == '0);

  always_ff @(posedge mclk) begin
    if (rst) begin
      lc <= '0;
    end else if (ldlc) begin
      lc <= load_val;                  // Load wins over counting
    end else if (csloop && !count_zero) begin
      lc <= lc - 1'b1;                 // Sticks at zero
    end
  end

  // Upper count bits must be clear for the nibble compare to count
  assign loop_done = (lc[mic_pkg::LOOP_W-1:mic_pkg::REG_W] == '0) &&
                     (lc[mic_pkg::REG_W-1:0] == lcc);

endmodule

`default_nettype wire

/* mic_operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_operand_select (
  input  logic                      mclk,
  input  logic                      rst,
  input  logic                      ldirv,
  input  logic [6:0]                cd_ir,
  input  logic [1:0]                csrasel,
  input  logic [1:0]                csrbsel,
  input  logic [mic_pkg::REG_W-1:0] csa,
  input  logic [mic_pkg::REG_W-1:0] csrb,
  input  logic [mic_pkg::REG_W-1:0] pil,
  input  logic [mic_pkg::REG_W-1:0] lc,
  output logic [mic_pkg::REG_W-1:0] laa,
  output logic [mic_pkg::REG_W-1:0] lba
);

  logic [6:0]                ir;      // Latched instruction field
  logic [mic_pkg::REG_W-1:0] laa_d;
  logic [mic_pkg::REG_W-1:0] lba_d;

  always_ff @(posedge mclk) begin
    if (rst) begin
      ir <= '0;
    end else if (ldirv) begin
      ir <= cd_ir;
    end
  end

  // A operand source
  always_comb begin
    case (csrasel)
      2'd0:    laa_d = csa;             // Straight from the micro-word
      2'd1:    laa_d = pil;             // Current priority level
      2'd2:    laa_d = ir[6:3];
      default: laa_d = lc;              // Indexed by loop count
    endcase
  end

  // B operand source
  always_comb begin
    case (csrbsel)
      2'd0:    lba_d = csrb;
      2'd1:    lba_d = {1'b0, ir[2:0]}; // Instruction reg field low
      2'd2:    lba_d = {1'b0, ir[5:3]}; // Instruction reg field high
      default: lba_d = lc;
    endcase
  end

  always_ff @(posedge mclk) begin
    if (rst) begin
      laa <= '0;
      lba <= '0;
    end else begin
      laa <= laa_d;
      lba <= lba_d;
    end
  end

endmodule

`default_nettype wire

/* mic_pkg.sv */
`default_nettype none

package mic_pkg;

  localparam int ADDR_W      = 13;  // Micro-address width
  localparam int REG_W       = 4;   // Register file address
  localparam int LOOP_W      = 6;
  localparam int STACK_DEPTH = 4;
  localparam int STK_CNT_W   = $clog2(STACK_DEPTH + 1);
  localparam int SC_W        = 4;   // Address source on top, stack op below

  // Stack operation in sc[1:0]
  localparam logic [1:0] STK_HOLD = 2'd0;
  localparam logic [1:0] STK_POP  = 2'd1;
  localparam logic [1:0] STK_LOAD = 2'd2;
  localparam logic [1:0] STK_PUSH = 2'd3;

  // Address source in sc[3:2]
  localparam logic [1:0] SRC_NEXT = 2'd0;
  localparam logic [1:0] SRC_JUMP = 2'd1;
  localparam logic [1:0] SRC_RET  = 2'd2;
  localparam logic [1:0] SRC_HOLD = 2'd3;

  // Test inputs, indices 8 to 15 are the inverted copies
  localparam int TEST_ZF        = 0;
  localparam int TEST_CRY       = 1;
  localparam int TEST_OVF       = 2;
  localparam int TEST_IRQ       = 3;
  localparam int TEST_STP       = 4;
  localparam int TEST_F11       = 5;
  localparam int TEST_F15       = 6;
  localparam int TEST_LOOP_DONE = 7;

  typedef struct packed {
    logic [REG_W-1:0] lcc;  // Loop compare value
    logic [SC_W-1:0]  fs;   // Sequencer code on false
    logic [3:0]       tsel; // Test select
  } cond_fields_t;

  // Low micro-word bits, read as jump target or as condition fields
  typedef union packed {
    logic [11:0]  target;
    cond_fields_t fields;
  } mic_word_t;

endpackage

`default_nettype wire

/* mic_return_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_return_stack (
  input  logic                       mclk,
  input  logic                       rst,
  input  logic [1:0]                 stack_op,
  input  logic [mic_pkg::ADDR_W-1:0] next_addr,
  output logic [mic_pkg::ADDR_W-1:0] ret,
  output logic                       deep
);

  localparam int Depth = mic_pkg::STACK_DEPTH;

  logic [mic_pkg::ADDR_W-1:0]    entry [Depth];  // Entry 0 is the top
  logic [mic_pkg::STK_CNT_W-1:0] count;

  always_ff @(posedge mclk) begin
    if (rst) begin
      for (int i = 0; i < Depth; i++) begin
        entry[i] <= '0;
      end
      count <= '0;
    end else begin
      case (stack_op)
        mic_pkg::STK_PUSH: begin
          entry[0] <= next_addr;
          for (int i = 1; i < Depth; i++) begin
            entry[i] <= entry[i-1];     // Oldest falls off the bottom
          end
          if (!deep) count <= count + 1'b1;
        end
        mic_pkg::STK_POP: begin
          for (int i = 0; i < Depth - 1; i++) begin
            entry[i] <= entry[i+1];
          end
          entry[Depth-1] <= '0;         // Keeps unused slots at zero
          if (count != '0) count <= count - 1'b1;
        end
        mic_pkg::STK_LOAD: begin
          entry[0] <= next_addr;
          if (count == '0) count <= 1'b1; // Top now holds a value
        end
        mic_pkg::STK_HOLD: ;
        default: ;
      endcase
    end
  end

  assign ret  = entry[0];
  assign deep = (count == mic_pkg::STK_CNT_W'(Depth));

endmodule

`default_nettype wire
